// File: hdl/alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// vector register and scalar widths
`define VLEN 64
`define VLENB (`VLEN/8)
`define XLEN 32

// element widths
`define BYTE_WIDTH 8
`define HWORD_WIDTH 16
`define WORD_WIDTH 32

// uop fields
`define ROB_DEPTH_WIDTH 3
`define UOP_INDEX_WIDTH 3
`define FUNCT6_WIDTH 6
`define FUNCT3_WIDTH 3

`endif

// File: hdl/rvv_isa_pkg.sv
`include "alu_defines.svh"

package rvv_isa_pkg;

  typedef enum logic [`FUNCT3_WIDTH-1:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVX = 3'b100,
    OPMVX = 3'b110
  } funct3_e;

  // only the codes this unit executes
  typedef enum logic [`FUNCT6_WIDTH-1:0] {
    VMINU      = 6'b000100,
    VMIN       = 6'b000101,
    VMAXU      = 6'b000110,
    VMAX       = 6'b000111,
    VXUNARY0   = 6'b010010,
    VMERGE_VMV = 6'b010111
  } funct6_e;

  // sub-opcode carried in the vs1 field
  typedef enum logic [4:0] {
    VZEXT_VF2 = 5'b00110,
    VSEXT_VF2 = 5'b00111
  } vxunary0_e;

  // merge_lanes shifts by this log2 byte count
  typedef enum logic [1:0] {
    EEW8  = 2'b00,
    EEW16 = 2'b01,
    EEW32 = 2'b10
  } eew_e;

endpackage

// File: hdl/alu_types_pkg.sv
`include "alu_defines.svh"

package alu_types_pkg;

  import rvv_isa_pkg::*;

  typedef logic [`VLEN-1:0]            vreg_t;
  typedef logic [`VLENB-1:0]           vmask_t;
  typedef logic [`XLEN-1:0]            xreg_t;
  typedef logic [`ROB_DEPTH_WIDTH-1:0] rob_entry_t;
  typedef logic [`UOP_INDEX_WIDTH-1:0] uop_index_t;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_MINMAX,
    OP_MOVE,
    OP_MERGE,
    OP_EXTEND
  } alu_op_e;

  // uop from the ALU reservation station
  typedef struct packed {
    rob_entry_t rob_entry;
    funct6_e    funct6;
    funct3_e    funct3;
    logic       vm;
    logic [4:0] vs1;
    vreg_t      v0_data;
    logic       v0_data_valid;
    vreg_t      vs1_data;
    logic       vs1_data_valid;
    vreg_t      vs2_data;
    logic       vs2_data_valid;
    xreg_t      rs1_data;
    logic       rs1_data_valid;
    eew_e       vd_eew;
    eew_e       vs2_eew;
    uop_index_t uop_index;
  } alu_uop_t;

  typedef struct packed {
    logic       valid;
    alu_op_e    op;
    logic       is_signed;
    logic       get_max;
    logic       sign_extend;
    eew_e       eew;
    vreg_t      src1;
    vreg_t      src2;
    vreg_t      v0_data;
    uop_index_t uop_index;
    rob_entry_t rob_entry;
  } decoded_uop_t;

  // result toward the ROB
  typedef struct packed {
    rob_entry_t rob_entry;
    vreg_t      w_data;
    logic       w_valid;
    logic       ignore_vma;
  } alu_result_t;

endpackage

// File: hdl/uop_decode.sv
`include "alu_defines.svh"

module uop_decode (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        uop_valid,
  input  alu_types_pkg::alu_uop_t     uop,
  output alu_types_pkg::decoded_uop_t dec
);

  import rvv_isa_pkg::*;
  import alu_types_pkg::*;

  alu_op_e op;
  logic    srcs_ok;
  logic    scalar;
  logic    src1_ok;
  eew_e    eew;
  vreg_t   vs2_half;

  // rs1 replicated into every element
  function automatic vreg_t broadcast(input xreg_t rs1, input eew_e width);
    case (width)
      EEW8:    return {(`VLEN/`BYTE_WIDTH){rs1[`BYTE_WIDTH-1:0]}};
      EEW16:   return {(`VLEN/`HWORD_WIDTH){rs1[`HWORD_WIDTH-1:0]}};
      default: return {(`VLEN/`WORD_WIDTH){rs1[`WORD_WIDTH-1:0]}};
    endcase
  endfunction

  assign scalar  = (uop.funct3 == OPIVX);
  assign src1_ok = scalar ? uop.rs1_data_valid : uop.vs1_data_valid;

  always_comb begin
    op      = OP_NONE;
    srcs_ok = 1'b0;
    eew     = uop.vs2_eew;
    case (uop.funct3)
      OPIVV, OPIVX: begin
        case (uop.funct6)
          VMINU, VMIN, VMAXU, VMAX: begin
            op      = OP_MINMAX;
            srcs_ok = src1_ok & uop.vs2_data_valid;
          end
          VMERGE_VMV: begin
            if (uop.vm) begin
              op      = OP_MOVE;
              srcs_ok = src1_ok;
              eew     = uop.vd_eew;
            end else begin
              op      = OP_MERGE;
              srcs_ok = src1_ok & uop.vs2_data_valid & uop.v0_data_valid;
            end
          end
          default: ;
        endcase
      end
      OPMVV: begin
        if (uop.funct6 == VXUNARY0 && (uop.vs1 == VZEXT_VF2 || uop.vs1 == VSEXT_VF2)) begin
          op      = OP_EXTEND;
          srcs_ok = uop.vs2_data_valid & ~uop.vs1_data_valid &
                    (uop.vs2_eew == EEW8 || uop.vs2_eew == EEW16);
        end
      end
      default: ;
    endcase
  end

  // selected half of vs2 in the low bits
  assign vs2_half = uop.uop_index[0] ? {{(`VLEN/2){1'b0}}, uop.vs2_data[`VLEN/2 +: `VLEN/2]}
                                     : {{(`VLEN/2){1'b0}}, uop.vs2_data[0 +: `VLEN/2]};

  assign dec.valid       = uop_valid & srcs_ok;
  assign dec.op          = op;
  assign dec.is_signed   = (uop.funct6 == VMIN) || (uop.funct6 == VMAX);
  assign dec.get_max     = (uop.funct6 == VMAXU) || (uop.funct6 == VMAX);
  assign dec.sign_extend = (uop.vs1 == VSEXT_VF2);
  assign dec.eew         = eew;
  assign dec.src1        = scalar ? broadcast(uop.rs1_data, eew) : uop.vs1_data;
  assign dec.src2        = (op == OP_EXTEND) ? vs2_half : uop.vs2_data;
  assign dec.v0_data     = uop.v0_data;
  assign dec.uop_index   = uop.uop_index;
  assign dec.rob_entry   = uop.rob_entry;

  a_minmax_sources: assert property (@(posedge clk) disable iff (!rst_n)
    dec.valid && dec.op == OP_MINMAX |-> !$isunknown({dec.src1, dec.src2}))
    else $error("min/max issued with unknown source data");

  a_extend_source: assert property (@(posedge clk) disable iff (!rst_n)
    dec.valid && dec.op == OP_EXTEND |-> !$isunknown(dec.src2))
    else $error("extend issued with unknown source data");

endmodule

// File: hdl/minmax_lanes.sv
`include "alu_defines.svh"

module minmax_lanes (
  input  alu_types_pkg::decoded_uop_t dec,
  output alu_types_pkg::vreg_t        minmax_data
);

  import rvv_isa_pkg::*;
  import alu_types_pkg::*;

  vreg_t width_res [3];

  // one lane set per element width
  for (genvar w = 0; w < 3; w++) begin : g_width
    localparam int EW = `BYTE_WIDTH << w;
    vreg_t lane_res;

    for (genvar i = 0; i < `VLEN/EW; i++) begin : g_elem
      logic signed [EW:0] op_a;
      logic signed [EW:0] op_b;
      logic               a_lt_b;

      // extra top bit makes one signed compare serve both orders
      assign op_a   = {dec.is_signed & dec.src2[i*EW+EW-1], dec.src2[i*EW +: EW]};
      assign op_b   = {dec.is_signed & dec.src1[i*EW+EW-1], dec.src1[i*EW +: EW]};
      assign a_lt_b = op_a < op_b;
      assign lane_res[i*EW +: EW] = (a_lt_b ^ dec.get_max) ? op_a[EW-1:0] : op_b[EW-1:0];
    end

    assign width_res[w] = lane_res;
  end

  always_comb begin
    case (dec.eew)
      EEW8:    minmax_data = width_res[0];
      EEW16:   minmax_data = width_res[1];
      EEW32:   minmax_data = width_res[2];
      default: minmax_data = '0;
    endcase
  end

endmodule

// File: hdl/extend_lanes.sv
`include "alu_defines.svh"

module extend_lanes (
  input  alu_types_pkg::decoded_uop_t dec,
  output alu_types_pkg::vreg_t        extend_data
);

  import rvv_isa_pkg::*;
  import alu_types_pkg::*;

  vreg_t width_res [2];

  // source 8 -> 16 and 16 -> 32
  for (genvar w = 0; w < 2; w++) begin : g_width
    localparam int SW = (w == 0) ? `BYTE_WIDTH : `HWORD_WIDTH;
    localparam int DW = 2 * SW;
    vreg_t lane_res;

    for (genvar i = 0; i < `VLEN/DW; i++) begin : g_elem
      logic fill;

      assign fill = dec.sign_extend & dec.src2[i*SW+SW-1];
      assign lane_res[i*DW +: DW] = {{SW{fill}}, dec.src2[i*SW +: SW]};
    end

    assign width_res[w] = lane_res;
  end

  always_comb begin
    case (dec.eew)
      EEW8:    extend_data = width_res[0];
      EEW16:   extend_data = width_res[1];
      default: extend_data = '0;
    endcase
  end

endmodule

// File: hdl/merge_lanes.sv
`include "alu_defines.svh"

module merge_lanes (
  input  alu_types_pkg::decoded_uop_t dec,
  output alu_types_pkg::vreg_t        merge_data
);

  import rvv_isa_pkg::*;
  import alu_types_pkg::*;

  vmask_t mask_in_use;
  vreg_t  width_res [3];

  // elements per register is VLENB >> eew
  assign mask_in_use = vmask_t'(dec.v0_data >> ((dec.uop_index * `VLENB) >> dec.eew));

  for (genvar w = 0; w < 3; w++) begin : g_width
    localparam int EW = `BYTE_WIDTH << w;
    vreg_t lane_res;

    for (genvar i = 0; i < `VLEN/EW; i++) begin : g_elem
      assign lane_res[i*EW +: EW] = mask_in_use[i] ? dec.src1[i*EW +: EW]
                                                   : dec.src2[i*EW +: EW];
    end

    assign width_res[w] = lane_res;
  end

  always_comb begin
    case (dec.eew)
      EEW8:    merge_data = width_res[0];
      EEW16:   merge_data = width_res[1];
      EEW32:   merge_data = width_res[2];
      default: merge_data = '0;
    endcase
  end

endmodule

// File: hdl/result_stage.sv
`include "alu_defines.svh"

module result_stage (
  input  logic                        clk,
  input  logic                        rst_n,
  input  alu_types_pkg::decoded_uop_t dec,
  input  alu_types_pkg::vreg_t        minmax_data,
  input  alu_types_pkg::vreg_t        extend_data,
  input  alu_types_pkg::vreg_t        merge_data,
  output logic                        result_valid,
  output alu_types_pkg::alu_result_t  result
);

  import alu_types_pkg::*;

  vreg_t w_data_next;

  always_comb begin
    w_data_next = '0;
    if (dec.valid) begin
      case (dec.op)
        OP_MINMAX: w_data_next = minmax_data;
        OP_MOVE:   w_data_next = dec.src1;
        OP_MERGE:  w_data_next = merge_data;
        OP_EXTEND: w_data_next = extend_data;
        default:   w_data_next = '0;
      endcase
    end
  end

  // single register stage toward the ROB
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      result       <= '0;
    end else begin
      result_valid      <= dec.valid;
      result.rob_entry  <= dec.rob_entry;
      result.w_data     <= w_data_next;
      result.w_valid    <= dec.valid;
      result.ignore_vma <= dec.valid && (dec.op == OP_MERGE);
    end
  end

  a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(result_valid))
    else $error("result_valid unknown after reset");

endmodule

// File: hdl/alu_other_top.sv
`include "alu_defines.svh"

module alu_other_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       uop_valid,
  input  alu_types_pkg::alu_uop_t    uop,
  output logic                       result_valid,
  output alu_types_pkg::alu_result_t result
);

  import alu_types_pkg::*;

  decoded_uop_t dec;
  vreg_t        minmax_data;
  vreg_t        extend_data;
  vreg_t        merge_data;

  uop_decode i_uop_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .uop_valid (uop_valid),
    .uop       (uop),
    .dec       (dec)
  );

  minmax_lanes i_minmax_lanes (
    .dec         (dec),
    .minmax_data (minmax_data)
  );

  extend_lanes i_extend_lanes (
    .dec         (dec),
    .extend_data (extend_data)
  );

  merge_lanes i_merge_lanes (
    .dec        (dec),
    .merge_data (merge_data)
  );

  result_stage i_result_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .dec          (dec),
    .minmax_data  (minmax_data),
    .extend_data  (extend_data),
    .merge_data   (merge_data),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

// File: tests/tb_clock.sv
module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reset held low for two rising edges
  initial begin
    rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: tests/tb_alu_other.sv
module tb_alu_other;

  import rvv_isa_pkg::*;
  import alu_types_pkg::*;

  typedef struct packed {
    logic     in_valid;
    alu_uop_t uop;
    logic     exp_valid;
    vreg_t    exp_data;
    logic     exp_ivma;
  } test_row_t;

  // operands whose signed and unsigned orders differ
  localparam vreg_t mm8_a    = 64'h8001_7fff_0010_fe02;
  localparam vreg_t mm8_b    = 64'h0180_8000_ff20_ff01;
  localparam vreg_t mm16_a   = 64'h8000_0001_7fff_1234;
  localparam vreg_t mm16_b   = 64'h0001_8000_8000_1235;
  localparam vreg_t mm32_a   = 64'h8000_0000_0000_0005;
  localparam vreg_t mm32_b   = 64'h0000_0001_ffff_ffff;
  localparam vreg_t mrg_src1 = 64'h1716_1514_1312_1110;
  localparam vreg_t mrg_src2 = 64'h2726_2524_2322_2120;
  localparam vreg_t mrg_v0   = 64'h0000_0000_0000_3c5a;
  localparam vreg_t ext8     = 64'h807f_ff01_f00f_817e;
  localparam vreg_t ext16    = 64'h8000_7fff_f00f_0ff0;

  logic        clk;
  logic        rst_n;
  logic        uop_valid;
  alu_uop_t    uop;
  logic        result_valid;
  alu_result_t result;

  test_row_t rows [$];
  int        error_count = 0;
  int        check_count = 0;
  int        cycle_count = 0;
  int        cycle_limit = 0;

  tb_clock i_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  alu_other_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .uop_valid    (uop_valid),
    .uop          (uop),
    .result_valid (result_valid),
    .result       (result)
  );

  task automatic check_value(input vreg_t actual, input vreg_t expected, input string what);
    check_count++;
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, actual, expected);
      error_count++;
    end
  endtask

  // src_valid is {v0, vs1, vs2, rs1}
  task automatic add_row(
    input logic       in_valid,
    input logic [5:0] f6,
    input logic [2:0] f3,
    input logic       vm,
    input logic [4:0] vs1_field,
    input logic [1:0] eew,
    input logic [2:0] index,
    input vreg_t      vs1_data,
    input vreg_t      vs2_data,
    input xreg_t      rs1_data,
    input vreg_t      v0_data,
    input logic [3:0] src_valid,
    input logic       exp_valid,
    input vreg_t      exp_data,
    input logic       exp_ivma
  );
    test_row_t r;
    r = '0;
    r.in_valid             = in_valid;
    r.uop.rob_entry        = rob_entry_t'(rows.size());
    r.uop.funct6           = funct6_e'(f6);
    r.uop.funct3           = funct3_e'(f3);
    r.uop.vm               = vm;
    r.uop.vs1              = vs1_field;
    r.uop.v0_data          = v0_data;
    r.uop.v0_data_valid    = src_valid[3];
    r.uop.vs1_data         = vs1_data;
    r.uop.vs1_data_valid   = src_valid[2];
    r.uop.vs2_data         = vs2_data;
    r.uop.vs2_data_valid   = src_valid[1];
    r.uop.rs1_data         = rs1_data;
    r.uop.rs1_data_valid   = src_valid[0];
    r.uop.vd_eew           = eew_e'(eew);
    r.uop.vs2_eew          = eew_e'(eew);
    r.uop.uop_index        = index;
    r.exp_valid            = exp_valid;
    r.exp_data             = exp_data;
    r.exp_ivma             = exp_ivma;
    rows.push_back(r);
  endtask

  task automatic fill_table();
    // vector-vector min/max
    add_row(1'b1, VMINU, OPIVV, 1'b1, 5'd0, EEW8, 3'd0, mm8_b, mm8_a, '0, '0, 4'b0110,
            1'b1, 64'h0101_7f00_0010_fe01, 1'b0);
    add_row(1'b1, VMIN, OPIVV, 1'b1, 5'd0, EEW8, 3'd0, mm8_b, mm8_a, '0, '0, 4'b0110,
            1'b1, 64'h8080_80ff_ff10_fe01, 1'b0);
    add_row(1'b1, VMAXU, OPIVV, 1'b1, 5'd0, EEW8, 3'd0, mm8_b, mm8_a, '0, '0, 4'b0110,
            1'b1, 64'h8080_80ff_ff20_ff02, 1'b0);
    add_row(1'b1, VMAX, OPIVV, 1'b1, 5'd0, EEW8, 3'd0, mm8_b, mm8_a, '0, '0, 4'b0110,
            1'b1, 64'h0101_7f00_0020_ff02, 1'b0);
    add_row(1'b1, VMINU, OPIVV, 1'b1, 5'd0, EEW16, 3'd0, mm16_b, mm16_a, '0, '0, 4'b0110,
            1'b1, 64'h0001_0001_7fff_1234, 1'b0);
    add_row(1'b1, VMIN, OPIVV, 1'b1, 5'd0, EEW16, 3'd0, mm16_b, mm16_a, '0, '0, 4'b0110,
            1'b1, 64'h8000_8000_8000_1234, 1'b0);
    add_row(1'b1, VMAXU, OPIVV, 1'b1, 5'd0, EEW16, 3'd0, mm16_b, mm16_a, '0, '0, 4'b0110,
            1'b1, 64'h8000_8000_8000_1235, 1'b0);
    add_row(1'b1, VMAX, OPIVV, 1'b1, 5'd0, EEW16, 3'd0, mm16_b, mm16_a, '0, '0, 4'b0110,
            1'b1, 64'h0001_0001_7fff_1235, 1'b0);
    add_row(1'b1, VMIN, OPIVV, 1'b1, 5'd0, EEW32, 3'd0, mm32_b, mm32_a, '0, '0, 4'b0110,
            1'b1, 64'h8000_0000_ffff_ffff, 1'b0);
    add_row(1'b1, VMINU, OPIVV, 1'b1, 5'd0, EEW32, 3'd0, mm32_b, mm32_a, '0, '0, 4'b0110,
            1'b1, 64'h0000_0001_0000_0005, 1'b0);
    add_row(1'b1, VMAXU, OPIVV, 1'b1, 5'd0, EEW32, 3'd0, mm32_b, mm32_a, '0, '0, 4'b0110,
            1'b1, 64'h8000_0000_ffff_ffff, 1'b0);
    add_row(1'b1, VMAX, OPIVV, 1'b1, 5'd0, EEW32, 3'd0, mm32_b, mm32_a, '0, '0, 4'b0110,
            1'b1, 64'h0000_0001_0000_0005, 1'b0);
    // scalar forms with rs1 broadcast
    add_row(1'b1, VMAXU, OPIVX, 1'b1, 5'd0, EEW8, 3'd0, '0, mm8_a, 32'h1234_5680, '0, 4'b0011,
            1'b1, 64'h8080_80ff_8080_fe80, 1'b0);
    add_row(1'b1, VMIN, OPIVX, 1'b1, 5'd0, EEW16, 3'd0, '0, mm16_a, 32'hdead_0010, '0, 4'b0011,
            1'b1, 64'h8000_0001_0010_0010, 1'b0);
    add_row(1'b1, VMAX, OPIVX, 1'b1, 5'd0, EEW32, 3'd0, '0, mm32_a, 32'h0000_0100, '0, 4'b0011,
            1'b1, 64'h0000_0100_0000_0100, 1'b0);
    add_row(1'b1, VMERGE_VMV, OPIVX, 1'b1, 5'd0, EEW8, 3'd0, '0, '0, 32'h0000_00a5, '0, 4'b0001,
            1'b1, 64'ha5a5_a5a5_a5a5_a5a5, 1'b0);
    add_row(1'b1, VMERGE_VMV, OPIVX, 1'b1, 5'd0, EEW16, 3'd0, '0, '0, 32'h0000_beef, '0, 4'b0001,
            1'b1, 64'hbeef_beef_beef_beef, 1'b0);
    add_row(1'b1, VMERGE_VMV, OPIVX, 1'b1, 5'd0, EEW32, 3'd0, '0, '0, 32'hcafe_f00d, '0, 4'b0001,
            1'b1, 64'hcafe_f00d_cafe_f00d, 1'b0);
    add_row(1'b1, VMERGE_VMV, OPIVV, 1'b1, 5'd0, EEW16, 3'd0, 64'h0123_4567_89ab_cdef, '0, '0,
            '0, 4'b0100, 1'b1, 64'h0123_4567_89ab_cdef, 1'b0);
    // merge under v0
    add_row(1'b1, VMERGE_VMV, OPIVV, 1'b0, 5'd0, EEW8, 3'd0, mrg_src1, mrg_src2, '0,
            mrg_v0, 4'b1110, 1'b1, 64'h2716_2514_1322_1120, 1'b1);
    add_row(1'b1, VMERGE_VMV, OPIVV, 1'b0, 5'd0, EEW8, 3'd1, mrg_src1, mrg_src2, '0,
            mrg_v0, 4'b1110, 1'b1, 64'h2726_1514_1312_2120, 1'b1);
    add_row(1'b1, VMERGE_VMV, OPIVV, 1'b0, 5'd0, EEW16, 3'd0, mrg_src1, mrg_src2, '0,
            mrg_v0, 4'b1110, 1'b1, 64'h1716_2524_1312_2120, 1'b1);
    add_row(1'b1, VMERGE_VMV, OPIVV, 1'b0, 5'd0, EEW16, 3'd1, mrg_src1, mrg_src2, '0,
            mrg_v0, 4'b1110, 1'b1, 64'h2726_1514_2322_1110, 1'b1);
    // extension by two with uop_index[0] picking the half
    add_row(1'b1, VXUNARY0, OPMVV, 1'b1, VZEXT_VF2, EEW8, 3'd0, '0, ext8, '0, '0, 4'b0010,
            1'b1, 64'h00f0_000f_0081_007e, 1'b0);
    add_row(1'b1, VXUNARY0, OPMVV, 1'b1, VSEXT_VF2, EEW8, 3'd1, '0, ext8, '0, '0, 4'b0010,
            1'b1, 64'hff80_007f_ffff_0001, 1'b0);
    add_row(1'b1, VXUNARY0, OPMVV, 1'b1, VZEXT_VF2, EEW16, 3'd1, '0, ext16, '0, '0, 4'b0010,
            1'b1, 64'h0000_8000_0000_7fff, 1'b0);
    add_row(1'b1, VXUNARY0, OPMVV, 1'b1, VSEXT_VF2, EEW16, 3'd0, '0, ext16, '0, '0, 4'b0010,
            1'b1, 64'hffff_f00f_0000_0ff0, 1'b0);
    // rejected uops
    add_row(1'b1, VMIN, OPIVV, 1'b1, 5'd0, EEW8, 3'd0, mm8_b, mm8_a, '0, '0, 4'b0010,
            1'b0, '0, 1'b0);
    add_row(1'b1, VXUNARY0, OPMVV, 1'b1, VSEXT_VF2, EEW32, 3'd0, '0, ext16, '0, '0, 4'b0010,
            1'b0, '0, 1'b0);
    add_row(1'b0, VMINU, OPIVV, 1'b1, 5'd0, EEW8, 3'd0, mm8_b, mm8_a, '0, '0, 4'b0110,
            1'b0, '0, 1'b0);
    add_row(1'b1, 6'b000000, OPIVV, 1'b1, 5'd0, EEW8, 3'd0, mm8_b, mm8_a, '0, '0, 4'b0110,
            1'b0, '0, 1'b0);
  endtask

  task automatic check_row(input int k);
    string tag;
    tag = $sformatf("row %0d", k);
    check_value(vreg_t'(result_valid), vreg_t'(rows[k].exp_valid), {tag, " result_valid"});
    check_value(vreg_t'(result.w_valid), vreg_t'(rows[k].exp_valid), {tag, " w_valid"});
    check_value(result.w_data, rows[k].exp_data, {tag, " w_data"});
    check_value(vreg_t'(result.rob_entry), vreg_t'(rows[k].uop.rob_entry), {tag, " rob_entry"});
    check_value(vreg_t'(result.ignore_vma), vreg_t'(rows[k].exp_ivma), {tag, " ignore_vma"});
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("run timed out after %0d cycles without finishing", cycle_count);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    uop_valid <= 1'b0;
    uop       <= '0;
    fill_table();
    // table, reset and some slack
    cycle_limit = rows.size() + 2 + 10;

    while (rst_n !== 1'b1) begin
      @(negedge clk);
    end
    check_value(vreg_t'(result_valid), '0, "result_valid after reset");
    check_value(result.w_data, '0, "w_data after reset");
    check_value(vreg_t'({result.rob_entry, result.w_valid, result.ignore_vma}), '0,
                "result control fields after reset");

    // row k goes in while row k-1 is checked
    for (int k = 0; k <= rows.size(); k++) begin
      @(posedge clk);
      if (k < rows.size()) begin
        uop_valid <= rows[k].in_valid;
        uop       <= rows[k].uop;
      end else begin
        uop_valid <= 1'b0;
        uop       <= '0;
      end
      @(negedge clk);
      if (k > 0) begin
        check_row(k - 1);
      end
    end

    $display("%0d checks run, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+hdl
hdl/rvv_isa_pkg.sv
hdl/alu_types_pkg.sv
hdl/uop_decode.sv
hdl/minmax_lanes.sv
hdl/extend_lanes.sv
hdl/merge_lanes.sv
hdl/result_stage.sv
hdl/alu_other_top.sv
tests/tb_clock.sv
tests/tb_alu_other.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f all.f \
		--top-module tb_alu_other -o sim_alu_other
	@out="$$(./obj_dir/sim_alu_other)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
